/* all.f */
logic/wb_bus_pkg.sv
logic/fill_cmd_pkg.sv
logic/wb_cmd_port.sv
logic/cmd_decode.sv
logic/beat_gen.sv
logic/wb_master_drive.sv
logic/team_04_wrapper.sv
tests/tb_team_04_wrapper.sv

/* logic/beat_gen.sv */
`timescale 1ns/1ps
/*
 * Expands a job into one write beat per cycle, no stall input
 * A job strobe while busy is not expected, cmd_decode waits on busy
 */
module beat_gen (
    input  logic                     wb_clk_i,
    input  logic                     rst_n_i,
    input  logic                     job_valid_i,
    input  fill_cmd_pkg::fill_job_t  job_i,
    output logic                     beat_valid_o,
    output logic                     beat_last_o,
    output logic                     busy_o,
    output fill_cmd_pkg::fill_beat_t beat_o
);
    import fill_cmd_pkg::*;

    logic        busy_q;
    logic [7:0]  idx_q;     // Current beat number
    logic [7:0]  last_q;    // Final beat number
    logic [31:0] step_q;    // Byte step between beats
    logic        incr_q;
    logic        at_last;
    fill_beat_t  beat_q;    // Running address and data

    assign at_last = (idx_q == last_q);

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
        end else if (job_valid_i) begin
            busy_q <= 1'b1;
        end else if (busy_q && at_last) begin
            busy_q <= 1'b0;  // Last beat goes out this cycle
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (job_valid_i) begin
            idx_q       <= 8'd0;
            last_q      <= job_i.last;
            step_q      <= {26'd0, job_i.stride, 2'b00};  // Words to bytes
            incr_q      <= job_i.incr;
            beat_q.addr <= job_i.base;
            beat_q.data <= job_i.pattern;
        end else if (busy_q) begin
            idx_q       <= idx_q + 8'd1;
            beat_q.addr <= beat_q.addr + step_q;
            beat_q.data <= beat_q.data + 32'(incr_q);  // Flat pattern if clear
        end
    end

    assign beat_valid_o = busy_q;
    assign beat_last_o  = busy_q & at_last;
    assign busy_o       = busy_q;
    assign beat_o       = beat_q;

endmodule

/* logic/cmd_decode.sv */
`timescale 1ns/1ps
/*
 * Takes one queued command at a time and hands it on as a job
 * Pop is a registered strobe, head must stay stable while it is high
 */
module cmd_decode (
    input  logic                    wb_clk_i,
    input  logic                    rst_n_i,
    input  fill_cmd_pkg::fill_cmd_t cmd_i,
    input  logic                    cmd_avail_i,
    input  logic                    busy_i,
    output logic                    pop_o,
    output logic                    reject_o,
    output logic                    job_valid_o,
    output fill_cmd_pkg::fill_job_t job_o
);
    import fill_cmd_pkg::*;

    logic      pop_q;
    logic      reject_q;
    logic      job_valid_q;
    logic      len_zero;
    fill_job_t job_q;

    assign len_zero = (cmd_i.length == 8'd0);

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            pop_q       <= 1'b0;
            reject_q    <= 1'b0;
            job_valid_q <= 1'b0;
        end else begin
            // Hold off while a popped command is still on its way to beat_gen
            pop_q       <= cmd_avail_i & ~busy_i & ~pop_q & ~job_valid_q;
            job_valid_q <= pop_q & ~len_zero;
            reject_q    <= pop_q & len_zero;  // Nothing issued for it
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (pop_q) begin
            job_q.base    <= cmd_i.base;
            job_q.pattern <= cmd_i.pattern;
            job_q.last    <= cmd_i.length - 8'd1;  // Only used when nonzero
            job_q.stride  <= cmd_i.stride;
            job_q.incr    <= cmd_i.incr;
        end
    end

    assign pop_o       = pop_q;
    assign reject_o    = reject_q;
    assign job_valid_o = job_valid_q;
    assign job_o       = job_q;

endmodule

/* logic/fill_cmd_pkg.sv */
/*
 * Fill engine command, job and beat words plus slave register map
 * Register index comes from address bits 3:2, one 32-bit word each
 */
package fill_cmd_pkg;

    // Slave register word offsets
    localparam logic [1:0] REG_BASE    = 2'd0;
    localparam logic [1:0] REG_PATTERN = 2'd1;
    localparam logic [1:0] REG_CTRL    = 2'd2;   // Write pushes a command
    localparam logic [1:0] REG_STATUS  = 2'd3;   // Read only

    // One command as software wrote it
    typedef struct packed {
        logic [31:0] base;     // First write address
        logic [31:0] pattern;  // First data word
        logic [7:0]  length;   // Beat count, zero is rejected
        logic [3:0]  stride;   // Address step in words
        logic        incr;     // Bump data by one per beat
    } fill_cmd_t;

    // Checked command, length already turned into last index
    typedef struct packed {
        logic [31:0] base;
        logic [31:0] pattern;
        logic [7:0]  last;     // Index of final beat
        logic [3:0]  stride;
        logic        incr;
    } fill_job_t;

    // Single master write
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } fill_beat_t;

    // REG_CTRL write data layout
    typedef struct packed {
        logic [18:0] rsvd;
        logic        incr;     // Bit 12
        logic [3:0]  stride;   // Bits 11:8
        logic [7:0]  length;   // Bits 7:0
    } ctrl_reg_t;

    // REG_STATUS read layout
    typedef struct packed {
        logic [7:0] rsvd_hi;
        logic [7:0] err;       // Bits 23:16
        logic [7:0] done;      // Bits 15:8
        logic [3:0] level;     // Bits 7:4, queue fill
        logic [2:0] rsvd_lo;
        logic       busy;      // Bit 0
    } status_t;

endpackage

/* logic/team_04_wrapper.sv */
`timescale 1ns/1ps
/*
 * Chip-level wrapper of the Wishbone memory fill engine
 * gpio_in_i, la_data_in_i and la_oenb_i are not used
 * Busy on la_data_out_o[0], done pulse on irq_o[0], done count on gpio_out_o[7:0]
 */
module team_04_wrapper #(
    parameter int CMD_DEPTH = 4
) (
    input  logic         wb_clk_i,
    input  logic         rst_n_i,
    input  logic         wbs_stb_i,
    input  logic         wbs_cyc_i,
    input  logic         wbs_we_i,
    input  logic [3:0]   wbs_sel_i,
    input  logic [31:0]  wbs_dat_i,
    input  logic [31:0]  wbs_adr_i,
    output logic         wbs_ack_o,
    output logic [31:0]  wbs_dat_o,
    input  logic [127:0] la_data_in_i,
    input  logic [127:0] la_oenb_i,
    output logic [127:0] la_data_out_o,
    input  logic [37:0]  gpio_in_i,
    output logic [37:0]  gpio_out_o,
    output logic [37:0]  gpio_oeb_o,
    output logic [2:0]   irq_o,
    output logic [31:0]  adr_o,
    output logic [31:0]  dat_o,
    output logic [3:0]   sel_o,
    output logic         we_o,
    output logic         stb_o,
    output logic         cyc_o
);
    import wb_bus_pkg::*;
    import fill_cmd_pkg::*;

    wb_req_t    s_req;      // From management core
    wb_rsp_t    s_rsp;
    wb_req_t    m_req;      // To memory side
    fill_cmd_t  cmd;
    fill_job_t  job;
    fill_beat_t beat;
    logic       cmd_avail;
    logic       pop;
    logic       reject;
    logic       job_valid;
    logic       beat_valid;
    logic       beat_last;
    logic       busy;
    logic       job_done;
    logic [7:0] done_count;

    assign s_req = '{adr: wbs_adr_i, dat: wbs_dat_i, sel: wbs_sel_i, we: wbs_we_i,
                     cyc: wbs_cyc_i, stb: wbs_stb_i};

    wb_cmd_port #(.CMD_DEPTH(CMD_DEPTH)) wb_cmd_port_i (
        .wb_clk_i(wb_clk_i), .rst_n_i(rst_n_i), .wb_req_i(s_req), .wb_rsp_o(s_rsp),
        .pop_i(pop), .cmd_o(cmd), .cmd_avail_o(cmd_avail), .reject_i(reject),
        .job_done_i(job_done), .busy_i(busy), .done_count_o(done_count)
    );

    cmd_decode cmd_decode_i (
        .wb_clk_i(wb_clk_i), .rst_n_i(rst_n_i), .cmd_i(cmd), .cmd_avail_i(cmd_avail),
        .busy_i(busy), .pop_o(pop), .reject_o(reject), .job_valid_o(job_valid), .job_o(job)
    );

    beat_gen beat_gen_i (
        .wb_clk_i(wb_clk_i), .rst_n_i(rst_n_i), .job_valid_i(job_valid), .job_i(job),
        .beat_valid_o(beat_valid), .beat_last_o(beat_last), .busy_o(busy), .beat_o(beat)
    );

    wb_master_drive wb_master_drive_i (
        .wb_clk_i(wb_clk_i), .rst_n_i(rst_n_i), .beat_valid_i(beat_valid),
        .beat_last_i(beat_last), .beat_i(beat), .wb_req_o(m_req), .job_done_o(job_done)
    );

    assign wbs_ack_o = s_rsp.ack;
    assign wbs_dat_o = s_rsp.dat;

    assign adr_o = m_req.adr;
    assign dat_o = m_req.dat;
    assign sel_o = m_req.sel;
    assign we_o  = m_req.we;
    assign stb_o = m_req.stb;
    assign cyc_o = m_req.cyc;

    assign la_data_out_o = {127'd0, busy};
    assign irq_o         = {2'b00, job_done};       // Done pulse on line 0
    assign gpio_out_o    = {30'd0, done_count};
    assign gpio_oeb_o    = {{30{1'b1}}, 8'h00};     // Low byte driven, rest inputs

endmodule

/* logic/wb_bus_pkg.sv */
/*
 * Wishbone request and response words for the slave and master sides
 * Classic single-cycle handshake only, no tags, no burst fields
 */
package wb_bus_pkg;

    // Request as seen at a port, master to slave
    typedef struct packed {
        logic [31:0] adr;   // Byte address
        logic [31:0] dat;   // Write data
        logic [3:0]  sel;   // Byte lane select
        logic        we;    // High for write
        logic        cyc;   // Bus cycle in progress
        logic        stb;   // Valid transfer
    } wb_req_t;

    // Response back to the master
    typedef struct packed {
        logic [31:0] dat;   // Read data, valid with ack
        logic        ack;   // One-cycle transfer ack
    } wb_rsp_t;

    // Widths for quick checks at the top
    localparam int WB_ADR_W = 32;
    localparam int WB_DAT_W = 32;
    localparam int WB_SEL_W = WB_DAT_W / 8;

endpackage

/* logic/wb_cmd_port.sv */
`timescale 1ns/1ps
/*
 * Slave side of the fill engine, acks every access one cycle later
 * CMD_DEPTH must be a power of two from 2 to 8 (level field is 4 bits)
 * CTRL write into a full queue is lost and counted as an error
 * Base and pattern staging registers power up unknown
 */
module wb_cmd_port #(
    parameter int CMD_DEPTH = 4
) (
    input  logic                    wb_clk_i,
    input  logic                    rst_n_i,
    input  wb_bus_pkg::wb_req_t     wb_req_i,
    output wb_bus_pkg::wb_rsp_t     wb_rsp_o,
    input  logic                    pop_i,
    output fill_cmd_pkg::fill_cmd_t cmd_o,
    output logic                    cmd_avail_o,
    input  logic                    reject_i,
    input  logic                    job_done_i,
    input  logic                    busy_i,
    output logic [7:0]              done_count_o
);
    import fill_cmd_pkg::*;

    localparam int PTR_W = $clog2(CMD_DEPTH);
    localparam int CNT_W = $clog2(CMD_DEPTH + 1);

    logic             req;        // New access this cycle
    logic             ctrl_wr;
    logic             push;
    logic             drop;
    logic             pop;
    logic             ack_q;
    logic [31:0]      rdata_q;
    logic [31:0]      base_q;
    logic [31:0]      pattern_q;
    fill_cmd_t        queue_q [CMD_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] cnt_q;
    logic [7:0]       done_q;
    logic [7:0]       err_q;
    ctrl_reg_t        ctrl;
    status_t          status;

    // Ack cycle itself never counts as a fresh request
    assign req     = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
    assign ctrl    = ctrl_reg_t'(wb_req_i.dat);
    assign ctrl_wr = req & wb_req_i.we & (wb_req_i.adr[3:2] == REG_CTRL);
    assign push    = ctrl_wr & (cnt_q != CNT_W'(CMD_DEPTH));
    assign drop    = ctrl_wr & (cnt_q == CNT_W'(CMD_DEPTH));  // Queue full
    assign pop     = pop_i & (cnt_q != '0);                   // Guard empty pop

    always_comb begin
        status       = '0;
        status.busy  = busy_i;
        status.level = 4'(cnt_q);
        status.done  = done_q;
        status.err   = err_q;
    end

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            ack_q    <= 1'b0;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
            done_q   <= '0;
            err_q    <= '0;
        end else begin
            ack_q <= req;
            if (push) begin
                wr_ptr_q <= wr_ptr_q + PTR_W'(1);  // Wraps at depth
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + PTR_W'(1);
            end
            cnt_q  <= cnt_q + CNT_W'(push) - CNT_W'(pop);
            done_q <= done_q + 8'(job_done_i);
            // Full-queue drop and zero-length reject may land together
            err_q  <= err_q + 8'(drop) + 8'(reject_i);
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (req && !wb_req_i.we) begin
            case (wb_req_i.adr[3:2])
                REG_BASE:    rdata_q <= base_q;
                REG_PATTERN: rdata_q <= pattern_q;
                REG_STATUS:  rdata_q <= status;
                default:     rdata_q <= '0;  // CTRL reads back zero
            endcase
        end
        for (int b = 0; b < 4; b++) begin
            if (req && wb_req_i.we && wb_req_i.sel[b]) begin
                if (wb_req_i.adr[3:2] == REG_BASE) begin
                    base_q[8*b +: 8] <= wb_req_i.dat[8*b +: 8];
                end
                if (wb_req_i.adr[3:2] == REG_PATTERN) begin
                    pattern_q[8*b +: 8] <= wb_req_i.dat[8*b +: 8];
                end
            end
        end
        if (push) begin
            queue_q[wr_ptr_q] <= '{base: base_q, pattern: pattern_q, length: ctrl.length,
                                   stride: ctrl.stride, incr: ctrl.incr};
        end
    end

    assign wb_rsp_o     = '{dat: rdata_q, ack: ack_q};
    assign cmd_o        = queue_q[rd_ptr_q];  // Head of queue
    assign cmd_avail_o  = (cnt_q != '0);
    assign done_count_o = done_q;

endmodule

/* logic/wb_master_drive.sv */
`timescale 1ns/1ps
/*
 * Puts each beat on the master port as a posted single-cycle write
 * No ack is sampled, the target must take one write per cycle
 */
module wb_master_drive (
    input  logic                     wb_clk_i,
    input  logic                     rst_n_i,
    input  logic                     beat_valid_i,
    input  logic                     beat_last_i,
    input  fill_cmd_pkg::fill_beat_t beat_i,
    output wb_bus_pkg::wb_req_t      wb_req_o,
    output logic                     job_done_o
);
    import wb_bus_pkg::*;

    wb_req_t req_q;
    logic    done_q;

    // Handshake bits, low whenever no beat came in
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            req_q.stb <= 1'b0;
            req_q.cyc <= 1'b0;
            req_q.we  <= 1'b0;
            req_q.sel <= '0;
            done_q    <= 1'b0;
        end else begin
            req_q.stb <= beat_valid_i;
            req_q.cyc <= beat_valid_i;
            req_q.we  <= beat_valid_i;  // Writes only
            req_q.sel <= {4{beat_valid_i}};
            done_q    <= beat_valid_i & beat_last_i;  // Same cycle as last strobe
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (beat_valid_i) begin
            req_q.adr <= beat_i.addr;
            req_q.dat <= beat_i.data;
        end
    end

    assign wb_req_o   = req_q;
    assign job_done_o = done_q;

endmodule

/* run.sh */
#!/bin/sh
# Build and run the fill engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module tb_team_04_wrapper -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1

/* tests/tb_team_04_wrapper.sv */
`timescale 1ns/1ps
/*
 * Directed tests of the fill engine through its chip-level pins
 * The master port has no target here, its writes are only observed
 * Assumes CMD_DEPTH of 4 and a 3000-cycle budget for the whole run
 */
module tb_team_04_wrapper;

    localparam int          CMD_DEPTH   = 4;
    localparam int          CYCLE_LIMIT = 3000;  // Longest run is about 300 cycles
    localparam logic [31:0] A_BASE      = 32'h0;
    localparam logic [31:0] A_PATTERN   = 32'h4;
    localparam logic [31:0] A_CTRL      = 32'h8;
    localparam logic [31:0] A_STATUS    = 32'hC;

    logic         clk;
    logic         rst_n;
    logic         wbs_stb;
    logic         wbs_cyc;
    logic         wbs_we;
    logic [3:0]   wbs_sel;
    logic [31:0]  wbs_dat;
    logic [31:0]  wbs_adr;
    logic         wbs_ack;
    logic [31:0]  wbs_rdat;
    logic [127:0] la_data_in;
    logic [127:0] la_oenb;
    logic [127:0] la_data_out;
    logic [37:0]  gpio_in;
    logic [37:0]  gpio_out;
    logic [37:0]  gpio_oeb;
    logic [2:0]   irq;
    logic [31:0]  adr_o;
    logic [31:0]  dat_o;
    logic [3:0]   sel_o;
    logic         we_o;
    logic         stb_o;
    logic         cyc_o;

    logic [31:0]  mon_adr [$];   // Observed master writes
    logic [31:0]  mon_dat [$];
    logic [31:0]  exp_adr [$];   // Reference beats
    logic [31:0]  exp_dat [$];
    int           irq_count;
    int           beats_seen;
    int           mismatches;
    int           failures;
    int           cycle_count;
    integer       seed;
    logic [7:0]   done_expected;  // Running done count

    team_04_wrapper #(.CMD_DEPTH(CMD_DEPTH)) team_04_wrapper_i (
        .wb_clk_i(clk), .rst_n_i(rst_n), .wbs_stb_i(wbs_stb), .wbs_cyc_i(wbs_cyc),
        .wbs_we_i(wbs_we), .wbs_sel_i(wbs_sel), .wbs_dat_i(wbs_dat), .wbs_adr_i(wbs_adr),
        .wbs_ack_o(wbs_ack), .wbs_dat_o(wbs_rdat), .la_data_in_i(la_data_in),
        .la_oenb_i(la_oenb), .la_data_out_o(la_data_out), .gpio_in_i(gpio_in),
        .gpio_out_o(gpio_out), .gpio_oeb_o(gpio_oeb), .irq_o(irq), .adr_o(adr_o),
        .dat_o(dat_o), .sel_o(sel_o), .we_o(we_o), .stb_o(stb_o), .cyc_o(cyc_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    // Watchdog
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles, the DUT never finished", cycle_count);
            $display("Testbench failed");
            $finish;
        end
    end

    // Master port monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n && (cyc_o !== stb_o || we_o !== stb_o)) begin
            failures++;
            $display("Master cycle or write enable does not follow strobe at %0t", $time);
        end
        if (rst_n && stb_o) begin
            mon_adr.push_back(adr_o);
            mon_dat.push_back(dat_o);
            beats_seen++;
            if (sel_o != 4'hf) begin
                failures++;
                $display("Master strobe without full byte select at %0t", $time);
            end
        end
        if (rst_n && irq[0]) begin
            irq_count++;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        mismatches++;
        $display("MISMATCH %s: expected %h, actual %h", name, exp_v, act_v);
    endtask

    // Done count on gpio_out[7:0], the rest of the side pins is fixed
    task automatic check_side_pins(input string name, input logic [7:0] done_exp);
        if (gpio_out[7:0] !== done_exp) begin
            report_mismatch({name, " gpio done"}, 32'(done_exp), 32'(gpio_out[7:0]));
        end
        if (gpio_out[37:8] !== 30'd0) begin
            report_mismatch({name, " gpio high"}, 32'd0, 32'(gpio_out[37:8]));
        end
        if (gpio_oeb[7:0] !== 8'h00) begin
            report_mismatch({name, " oeb low"}, 32'd0, 32'(gpio_oeb[7:0]));
        end
        if (gpio_oeb[37:8] !== {30{1'b1}}) begin
            report_mismatch({name, " oeb high"}, 32'h3FFF_FFFF, 32'(gpio_oeb[37:8]));
        end
        if (irq[2:1] !== 2'b00) begin
            report_mismatch({name, " irq high"}, 32'd0, 32'(irq[2:1]));
        end
        if (la_data_out[127:1] !== '0) begin
            failures++;
            $display("%s: logic analyzer bits above bit 0 are not zero", name);
        end
    endtask

    task automatic wb_write(input logic [31:0] adr, input logic [31:0] dat);
        @(posedge clk);
        #10;
        wbs_adr = adr;
        wbs_dat = dat;
        wbs_sel = 4'hf;
        wbs_we  = 1'b1;
        wbs_cyc = 1'b1;
        wbs_stb = 1'b1;
        do begin
            @(posedge clk);
            #10;
        end while (!wbs_ack);
        wbs_stb = 1'b0;  // Drop right after ack
        wbs_cyc = 1'b0;
        wbs_we  = 1'b0;
    endtask

    task automatic wb_read(input logic [31:0] adr, output logic [31:0] dat);
        @(posedge clk);
        #10;
        wbs_adr = adr;
        wbs_we  = 1'b0;
        wbs_cyc = 1'b1;
        wbs_stb = 1'b1;
        do begin
            @(posedge clk);
            #10;
        end while (!wbs_ack);
        dat     = wbs_rdat;  // Valid with ack
        wbs_stb = 1'b0;
        wbs_cyc = 1'b0;
    endtask

    task automatic push_cmd(input logic [31:0] base, input logic [31:0] pattern,
                            input logic [7:0] len, input logic [3:0] stride, input logic incr);
        wb_write(A_BASE, base);
        wb_write(A_PATTERN, pattern);
        wb_write(A_CTRL, {19'd0, incr, stride, len});
    endtask

    // Beat i goes to base + 4*stride*i
    task automatic expect_fill(input logic [31:0] base, input logic [31:0] pattern,
                               input logic [7:0] len, input logic [3:0] stride, input logic incr);
        for (int i = 0; i < int'(len); i++) begin
            exp_adr.push_back(base + 32'(stride) * 32'd4 * 32'(i));
            exp_dat.push_back(incr ? pattern + 32'(i) : pattern);
        end
    endtask

    task automatic compare_beats(input string name);
        if (mon_adr.size() != exp_adr.size()) begin
            report_mismatch({name, " beat count"}, 32'(exp_adr.size()), 32'(mon_adr.size()));
        end
        for (int i = 0; i < exp_adr.size() && i < mon_adr.size(); i++) begin
            if (mon_adr[i] !== exp_adr[i]) begin
                report_mismatch({name, " addr"}, exp_adr[i], mon_adr[i]);
            end
            if (mon_dat[i] !== exp_dat[i]) begin
                report_mismatch({name, " data"}, exp_dat[i], mon_dat[i]);
            end
        end
        mon_adr.delete();
        mon_dat.delete();
        exp_adr.delete();
        exp_dat.delete();
    endtask

    // Poll STATUS until done count reaches target
    task automatic wait_done(input logic [7:0] target);
        logic [31:0] st;
        do begin
            wb_read(A_STATUS, st);
        end while (st[15:8] != target);
        check_side_pins("done", target);
    endtask

    task automatic check_after_reset();
        logic [31:0] st;
        if (stb_o !== 1'b0) report_mismatch("reset stb", 32'd0, 32'(stb_o));
        if (cyc_o !== 1'b0) report_mismatch("reset cyc", 32'd0, 32'(cyc_o));
        if (we_o !== 1'b0) report_mismatch("reset we", 32'd0, 32'(we_o));
        if (wbs_ack !== 1'b0) report_mismatch("reset ack", 32'd0, 32'(wbs_ack));
        if (irq !== 3'd0) report_mismatch("reset irq", 32'd0, 32'(irq));
        check_side_pins("reset", 8'd0);
        wb_read(A_STATUS, st);
        if (st !== 32'd0) report_mismatch("reset status", 32'd0, st);
    endtask

    task automatic fill_single();
        int          irq_before;
        int          lat;
        logic [31:0] st;
        irq_before = irq_count;
        push_cmd(32'h1000_0000, 32'hA5A5_5A5A, 8'd6, 4'd1, 1'b0);
        expect_fill(32'h1000_0000, 32'hA5A5_5A5A, 8'd6, 4'd1, 1'b0);
        lat = 0;
        while (!stb_o) begin  // Cycles from CTRL ack to first strobe
            @(posedge clk);
            #10;
            lat++;
        end
        if (lat != 4) report_mismatch("single latency", 32'd4, 32'(lat));
        done_expected = 8'd1;
        wait_done(done_expected);
        compare_beats("single");
        if (irq_count - irq_before != 1) begin
            report_mismatch("single irq", 32'd1, 32'(irq_count - irq_before));
        end
        wb_read(A_STATUS, st);
        if (st !== 32'h0000_0100) report_mismatch("single status", 32'h0000_0100, st);
    endtask

    task automatic fill_stride_incr();
        logic [31:0] pat;
        pat = $random(seed);
        push_cmd(32'h2000_0100, pat, 8'd5, 4'd3, 1'b1);
        expect_fill(32'h2000_0100, pat, 8'd5, 4'd3, 1'b1);
        done_expected++;
        wait_done(done_expected);
        compare_beats("stride_incr");
    endtask

    task automatic fill_back_to_back();
        int          irq_before;
        logic [31:0] pat;
        irq_before = irq_count;
        pat = $random(seed);
        // Long first job so the other two sit in the queue
        push_cmd(32'h3000_0000, 32'h1111_0000, 8'd20, 4'd1, 1'b1);
        push_cmd(32'h3100_0040, pat, 8'd3, 4'd2, 1'b0);
        push_cmd(32'h3200_0000, 32'hCAFE_0000, 8'd4, 4'd15, 1'b1);
        expect_fill(32'h3000_0000, 32'h1111_0000, 8'd20, 4'd1, 1'b1);
        expect_fill(32'h3100_0040, pat, 8'd3, 4'd2, 1'b0);
        expect_fill(32'h3200_0000, 32'hCAFE_0000, 8'd4, 4'd15, 1'b1);
        done_expected += 8'd3;
        wait_done(done_expected);
        compare_beats("back_to_back");
        if (irq_count - irq_before != 3) begin
            report_mismatch("back_to_back irq", 32'd3, 32'(irq_count - irq_before));
        end
    endtask

    task automatic fill_errors();
        logic [31:0] st;
        logic [7:0]  err0;
        logic [31:0] pat;
        logic [31:0] k_base;
        logic [31:0] k_pat;
        wb_read(A_STATUS, st);
        err0 = st[23:16];
        push_cmd(32'h4000_0000, 32'h5555_5555, 8'd0, 4'd1, 1'b0);  // Zero length
        do begin
            wb_read(A_STATUS, st);
        end while (st[23:16] == err0);
        if (st[23:16] != err0 + 8'd1) begin
            report_mismatch("zero_len err", 32'(err0 + 8'd1), 32'(st[23:16]));
        end
        // A leaked zero-length job would have strobed by now
        repeat (2) @(posedge clk);
        #10;
        compare_beats("zero_len");
        // Keep the engine busy, then fill the queue
        pat = $random(seed);
        push_cmd(32'h5000_0000, pat, 8'd60, 4'd1, 1'b1);
        expect_fill(32'h5000_0000, pat, 8'd60, 4'd1, 1'b1);
        for (int k = 0; k < CMD_DEPTH; k++) begin
            k_base = 32'h5100_0000 + 32'(k) * 32'h100;
            k_pat  = 32'h6000_0000 + 32'(k);
            push_cmd(k_base, k_pat, 8'd2, 4'd1, 1'b0);
            expect_fill(k_base, k_pat, 8'd2, 4'd1, 1'b0);
        end
        wb_read(A_STATUS, st);
        if (st[7:4] != 4'(CMD_DEPTH)) report_mismatch("full level", 32'(CMD_DEPTH), 32'(st[7:4]));
        push_cmd(32'h5F00_0000, 32'hDEAD_BEEF, 8'd2, 4'd1, 1'b0);  // Dropped
        wb_read(A_STATUS, st);
        if (st[23:16] != err0 + 8'd2) begin
            report_mismatch("full err", 32'(err0 + 8'd2), 32'(st[23:16]));
        end
        done_expected += 8'(CMD_DEPTH + 1);
        wait_done(done_expected);
        compare_beats("queue_full");
    endtask

    task automatic busy_flag();
        logic [31:0] st;
        push_cmd(32'h7000_0000, 32'h0F0F_0F0F, 8'd8, 4'd2, 1'b0);
        expect_fill(32'h7000_0000, 32'h0F0F_0F0F, 8'd8, 4'd2, 1'b0);
        while (!stb_o) begin
            @(posedge clk);
            #10;
        end
        while (stb_o) begin
            // Busy drops together with the last strobe
            if (!irq[0] && la_data_out[0] !== 1'b1) begin
                report_mismatch("busy high", 32'd1, 32'(la_data_out[0]));
            end
            @(posedge clk);
            #10;
        end
        if (la_data_out[0] !== 1'b0) report_mismatch("busy low", 32'd0, 32'(la_data_out[0]));
        done_expected++;
        wait_done(done_expected);
        compare_beats("busy");
        wb_read(A_STATUS, st);
        if (st[0] !== 1'b0) report_mismatch("busy status", 32'd0, 32'(st[0]));
    endtask

    initial begin
        rst_n         = 1'b0;
        wbs_stb       = 1'b0;
        wbs_cyc       = 1'b0;
        wbs_we        = 1'b0;
        wbs_sel       = 4'h0;
        wbs_dat       = 32'd0;
        wbs_adr       = 32'd0;
        la_data_in    = '0;
        la_oenb       = '0;
        gpio_in       = '0;
        irq_count     = 0;
        beats_seen    = 0;
        mismatches    = 0;
        failures      = 0;
        cycle_count   = 0;
        seed          = 32'h2d69_74b3;
        done_expected = 8'd0;
        repeat (5) @(posedge clk);
        #10;
        rst_n = 1'b1;
        check_after_reset();
        fill_single();
        fill_stride_incr();
        fill_back_to_back();
        fill_errors();
        busy_flag();
        $display("Beats seen: %0d, mismatches: %0d, other failures: %0d",
                 beats_seen, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
